// File: src/obi_bus_pkg.sv
// ----------------------------------------------------------------------
// Bus widths and packed request and response structs of the requester
// port and of the plain memory port of the atomic resolver
// Include this package first in the compile order
// ----------------------------------------------------------------------

package obi_bus_pkg;

  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 32;
  localparam int unsigned id_w   = 4;
  localparam int unsigned be_w   = data_w / 8;
  localparam int unsigned atop_w = 6;

  // Requester side request, including the response ready
  typedef struct packed {
    logic              req;
    logic [addr_w-1:0] addr;
    logic              we;
    logic [be_w-1:0]   be;
    logic [data_w-1:0] wdata;
    logic [id_w-1:0]   aid;
    logic [atop_w-1:0] atop;
    logic              rready;
  } sbr_req_t;

  // Requester side response
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic [id_w-1:0]   rid;
    logic              err;
    logic              exokay;
  } sbr_rsp_t;

  // Memory side request, no atomic field
  typedef struct packed {
    logic              req;
    logic [addr_w-1:0] addr;
    logic              we;
    logic [be_w-1:0]   be;
    logic [data_w-1:0] wdata;
    logic [id_w-1:0]   aid;
  } mem_req_t;

  // Memory side response, the memory always accepts rready
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic              err;
  } mem_rsp_t;

  // One word held in the response buffer
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              err;
    logic              exokay;
  } rsp_entry_t;

endpackage

// File: src/atop_pkg.sv
// ----------------------------------------------------------------------
// Atomic operation types of the resolver: opcode encoding, sequencer
// states, reservation record and SC outcome
// Compile after obi_bus_pkg, whose widths it uses
// ----------------------------------------------------------------------

package atop_pkg;

  // Adder width of the AMO unit, two guard bits for the compares
  localparam int unsigned alu_w = obi_bus_pkg::data_w + 2;

  // RISC-V funct5 in the low bits, bit 5 flags any atomic
  typedef enum logic [obi_bus_pkg::atop_w-1:0] {
    NONE    = 6'h00,
    AMOADD  = 6'h20,
    AMOSWAP = 6'h21,
    LR      = 6'h22,
    SC      = 6'h23,
    AMOXOR  = 6'h24,
    AMOOR   = 6'h28,
    AMOAND  = 6'h2c,
    AMOMIN  = 6'h30,
    AMOMAX  = 6'h34,
    AMOMINU = 6'h38,
    AMOMAXU = 6'h3c
  } atop_e;

  typedef enum logic [1:0] {
    IDLE,
    AMO_WAIT_RD,
    AMO_WRITE
  } seq_state_e;

  // A single reservation, owned by one requester id
  typedef struct packed {
    logic                             valid;
    logic [obi_bus_pkg::addr_w-1:0]   addr;
    logic [obi_bus_pkg::id_w-1:0]     owner;
  } reservation_t;

  // Outcome of the SC in the request phase
  typedef struct packed {
    logic valid;
    logic success;
  } sc_result_t;

endpackage

// File: src/atop_reservation.sv
// ----------------------------------------------------------------------
// LR/SC reservation tracking for the atomic resolver
// Decides in the request cycle whether an SC succeeds and updates the
// reservation on every accepted request; exokay follows one cycle later
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module atop_reservation (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  obi_bus_pkg::sbr_req_t obi_req_i,
  input  logic                  accept_i,
  output logic                  sc_fail_o,
  output logic                  exokay_o
);

  atop_pkg::reservation_t res_q, res_d;
  atop_pkg::sc_result_t   sc_res;
  atop_pkg::atop_e        op;
  logic                   own;
  logic                   hit;
  logic                   is_store;
  logic                   exokay_d;

  assign op  = atop_pkg::atop_e'(obi_req_i.atop);
  assign own = res_q.valid && (res_q.owner == obi_req_i.aid);
  assign hit = (res_q.addr == obi_req_i.addr);

  // Plain stores and read-modify-write AMOs both change memory
  assign is_store = ((op == atop_pkg::NONE) && obi_req_i.we) ||
                    (op[5] && !(op inside {atop_pkg::LR, atop_pkg::SC}));

  assign sc_res.valid   = (op == atop_pkg::SC);
  assign sc_res.success = own && hit;
  assign sc_fail_o      = sc_res.valid && !sc_res.success;

  always_comb begin
    res_d    = res_q;
    exokay_d = 1'b0;
    if (accept_i) begin
      if (op == atop_pkg::LR) begin
        exokay_d = 1'b1;
        // A held reservation is only replaced by its own requester
        if (!res_q.valid || res_q.owner == obi_req_i.aid) begin
          res_d.valid = 1'b1;
          res_d.addr  = obi_req_i.addr;
          res_d.owner = obi_req_i.aid;
        end
      end
      if (is_store && hit && (res_q.owner != obi_req_i.aid)) begin
        res_d.valid = 1'b0;
      end
      // The owner's SC ends the reservation whether it succeeds or not
      if (sc_res.valid && own) begin
        res_d.valid = 1'b0;
      end
      if (sc_res.valid && sc_res.success) begin
        exokay_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q    <= '0;
      exokay_o <= 1'b0;
    end else begin
      res_q    <= res_d;
      exokay_o <= exokay_d;
    end
  end

endmodule

// File: src/atop_sequencer.sv
// ----------------------------------------------------------------------
// Request sequencer of the atomic resolver
// Forwards plain requests to memory, turns each AMO into a read and a
// write-back, and turns a failing SC into a plain read
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module atop_sequencer (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  obi_bus_pkg::sbr_req_t            obi_req_i,
  input  obi_bus_pkg::mem_rsp_t            mem_rsp_i,
  input  logic                             buf_ready_i,
  input  logic                             sc_fail_i,
  input  logic [obi_bus_pkg::data_w-1:0]   alu_result_i,
  output logic                             gnt_o,
  output logic                             accept_o,
  output logic                             amo_wb_o,
  output obi_bus_pkg::mem_req_t            mem_req_o,
  output atop_pkg::atop_e                  op_o,
  output logic [obi_bus_pkg::data_w-1:0]   operand_o
);

  atop_pkg::seq_state_e             state_q, state_d;
  atop_pkg::atop_e                  req_op;
  atop_pkg::atop_e                  op_q;
  logic [obi_bus_pkg::addr_w-1:0]   addr_q;
  logic [obi_bus_pkg::id_w-1:0]     aid_q;
  logic [obi_bus_pkg::data_w-1:0]   operand_q;
  logic [obi_bus_pkg::data_w-1:0]   result_q;
  logic                             is_amo;
  logic                             load_amo;
  logic                             hold_result;

  assign req_op = atop_pkg::atop_e'(obi_req_i.atop);
  assign is_amo = req_op[5] && !(req_op inside {atop_pkg::LR, atop_pkg::SC});

  assign op_o      = op_q;
  assign operand_o = operand_q;

  always_comb begin
    state_d     = state_q;
    load_amo    = 1'b0;
    hold_result = 1'b0;
    amo_wb_o    = 1'b0;
    gnt_o       = 1'b0;
    accept_o    = 1'b0;

    mem_req_o.req   = 1'b0;
    mem_req_o.addr  = obi_req_i.addr;
    mem_req_o.we    = obi_req_i.we;
    mem_req_o.be    = obi_req_i.be;
    mem_req_o.wdata = obi_req_i.wdata;
    mem_req_o.aid   = obi_req_i.aid;

    unique case (state_q)
      atop_pkg::IDLE: begin
        mem_req_o.req = obi_req_i.req && buf_ready_i;
        gnt_o         = buf_ready_i && mem_rsp_i.gnt;
        accept_o      = obi_req_i.req && gnt_o;
        // LR and the AMO read phase never write, a failing SC only reads
        if (req_op == atop_pkg::SC) begin
          mem_req_o.we = !sc_fail_i;
        end else if (req_op == atop_pkg::LR || is_amo) begin
          mem_req_o.we = 1'b0;
        end
        if (accept_o && is_amo) begin
          load_amo = 1'b1;
          state_d  = atop_pkg::AMO_WAIT_RD;
        end
      end
      // ------------------------------------------------------------------
      // Write-back phase, the memory port belongs to the AMO
      // ------------------------------------------------------------------
      atop_pkg::AMO_WAIT_RD, atop_pkg::AMO_WRITE: begin
        mem_req_o.we    = 1'b1;
        mem_req_o.addr  = addr_q;
        mem_req_o.aid   = aid_q;
        mem_req_o.be    = {obi_bus_pkg::be_w{1'b1}};
        mem_req_o.wdata = (state_q == atop_pkg::AMO_WRITE) ? result_q : alu_result_i;
        if (state_q == atop_pkg::AMO_WRITE || mem_rsp_i.rvalid) begin
          mem_req_o.req = 1'b1;
          amo_wb_o      = 1'b1;
          if (mem_rsp_i.gnt) begin
            state_d = atop_pkg::IDLE;
          end else if (state_q == atop_pkg::AMO_WAIT_RD) begin
            // Read data is gone next cycle, so keep the result
            state_d     = atop_pkg::AMO_WRITE;
            hold_result = 1'b1;
          end
        end
      end
      default: state_d = atop_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= atop_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      addr_q    <= obi_req_i.addr;
      aid_q     <= obi_req_i.aid;
      op_q      <= req_op;
      operand_q <= obi_req_i.wdata;
    end
    if (hold_result) begin
      result_q <= alu_result_i;
    end
  end

endmodule

// File: src/amo_alu.sv
// ----------------------------------------------------------------------
// Combinational AMO result unit
// One 34-bit adder serves AMOADD and the four min/max compares, where
// the operand is negated and the sign of the sum gives the order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module amo_alu (
  input  atop_pkg::atop_e                op_i,
  input  logic [obi_bus_pkg::data_w-1:0] mem_word_i,
  input  logic [obi_bus_pkg::data_w-1:0] operand_i,
  output logic [obi_bus_pkg::data_w-1:0] result_o
);

  localparam int unsigned dw = obi_bus_pkg::data_w;

  logic [atop_pkg::alu_w-1:0] add_a;
  logic [atop_pkg::alu_w-1:0] ext_b;
  logic [atop_pkg::alu_w-1:0] add_b;
  logic [atop_pkg::alu_w-1:0] sum;
  logic                       is_signed;
  logic                       is_cmp;
  logic                       lt;

  assign is_signed = (op_i inside {atop_pkg::AMOMIN, atop_pkg::AMOMAX});
  assign is_cmp    = (op_i inside {atop_pkg::AMOMIN, atop_pkg::AMOMAX,
                                   atop_pkg::AMOMINU, atop_pkg::AMOMAXU});

  // Sign extension only for the signed compares, zeros otherwise
  assign add_a = {{2{is_signed & mem_word_i[dw-1]}}, mem_word_i};
  assign ext_b = {{2{is_signed & operand_i[dw-1]}}, operand_i};
  assign add_b = is_cmp ? (~ext_b + atop_pkg::alu_w'(1)) : ext_b;
  assign sum   = add_a + add_b;

  // Memory word below operand when the difference is negative
  assign lt = sum[atop_pkg::alu_w-1];

  always_comb begin
    unique case (op_i)
      atop_pkg::AMOSWAP: result_o = operand_i;
      atop_pkg::AMOADD:  result_o = sum[dw-1:0];
      atop_pkg::AMOXOR:  result_o = mem_word_i ^ operand_i;
      atop_pkg::AMOAND:  result_o = mem_word_i & operand_i;
      atop_pkg::AMOOR:   result_o = mem_word_i | operand_i;
      atop_pkg::AMOMIN,
      atop_pkg::AMOMINU: result_o = lt ? mem_word_i : operand_i;
      atop_pkg::AMOMAX,
      atop_pkg::AMOMAXU: result_o = lt ? operand_i : mem_word_i;
      default:           result_o = operand_i;
    endcase
  end

endmodule

// File: src/rsp_buffer.sv
// ----------------------------------------------------------------------
// In-order response path of the atomic resolver
// Ids are queued at accept, memory data enters a two-entry fall-through
// FIFO, and the AMO write-back responses are dropped
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module rsp_buffer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           accept_i,
  input  logic [obi_bus_pkg::id_w-1:0]   aid_i,
  input  logic                           sc_i,
  input  logic                           exokay_i,
  input  logic                           amo_wb_i,
  input  obi_bus_pkg::mem_rsp_t          mem_rsp_i,
  input  logic                           rready_i,
  output logic                           ready_o,
  output logic                           rvalid_o,
  output logic [obi_bus_pkg::data_w-1:0] rdata_o,
  output logic [obi_bus_pkg::id_w-1:0]   rid_o,
  output logic                           err_o,
  output logic                           exokay_o
);

  // Id queue, one slot per accepted request
  logic [obi_bus_pkg::id_w-1:0] id_q [2];
  logic [1:0]                   sc_q;
  logic [1:0]                   ok_q;
  logic                         id_wr_q, id_rd_q, last_q, acc_q;
  logic [1:0]                   id_cnt_q;

  // Data FIFO
  obi_bus_pkg::rsp_entry_t fifo_q [2];
  obi_bus_pkg::rsp_entry_t push_entry, head;
  logic                    f_wr_q, f_rd_q;
  logic [1:0]              f_cnt_q;
  logic                    wb_pend_q;
  logic                    push, pop, store, drop;
  logic                    slot, slot_ok;

  // Data arrives in order, so it belongs to the oldest id without data
  assign slot    = id_rd_q ^ f_cnt_q[0];
  assign slot_ok = (acc_q && last_q == slot) ? exokay_i : ok_q[slot];

  assign push              = mem_rsp_i.rvalid && !wb_pend_q;
  assign push_entry.data   = sc_q[slot] ? {{(obi_bus_pkg::data_w-1){1'b0}}, !slot_ok}
                                        : mem_rsp_i.rdata;
  assign push_entry.err    = mem_rsp_i.err;
  assign push_entry.exokay = slot_ok;

  assign head     = (f_cnt_q != 2'd0) ? fifo_q[f_rd_q] : push_entry;
  assign rvalid_o = (f_cnt_q != 2'd0) || push;
  assign pop      = rvalid_o && rready_i;
  assign store    = push && !(pop && f_cnt_q == 2'd0);
  assign drop     = pop && (f_cnt_q != 2'd0);

  assign rdata_o  = head.data;
  assign err_o    = head.err;
  assign exokay_o = head.exokay;
  assign rid_o    = id_q[id_rd_q];
  assign ready_o  = (id_cnt_q != 2'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_wr_q   <= 1'b0;
      id_rd_q   <= 1'b0;
      last_q    <= 1'b0;
      acc_q     <= 1'b0;
      id_cnt_q  <= 2'd0;
      f_wr_q    <= 1'b0;
      f_rd_q    <= 1'b0;
      f_cnt_q   <= 2'd0;
      wb_pend_q <= 1'b0;
    end else begin
      acc_q <= accept_i;
      if (accept_i) begin
        id_wr_q <= !id_wr_q;
        last_q  <= id_wr_q;
      end
      if (pop) begin
        id_rd_q <= !id_rd_q;
      end
      id_cnt_q <= id_cnt_q + 2'(accept_i) - 2'(pop);
      if (store) begin
        f_wr_q <= !f_wr_q;
      end
      if (drop) begin
        f_rd_q <= !f_rd_q;
      end
      f_cnt_q <= f_cnt_q + 2'(store) - 2'(drop);
      // The write-back response is the next memory response after its grant
      if (amo_wb_i && mem_rsp_i.gnt) begin
        wb_pend_q <= 1'b1;
      end else if (mem_rsp_i.rvalid) begin
        wb_pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      id_q[id_wr_q] <= aid_i;
      sc_q[id_wr_q] <= sc_i;
    end
    if (acc_q) begin
      ok_q[last_q] <= exokay_i;
    end
    if (store) begin
      fifo_q[f_wr_q] <= push_entry;
    end
  end

endmodule

// File: src/atop_resolver.sv
// ----------------------------------------------------------------------
// Atomic operation resolver for one requester in front of a memory
// without atomic support
// Connect obi_req_i/obi_rsp_o to the requester, mem_* to the memory
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module atop_resolver (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  obi_bus_pkg::sbr_req_t obi_req_i,
  output obi_bus_pkg::sbr_rsp_t obi_rsp_o,
  output obi_bus_pkg::mem_req_t mem_req_o,
  input  obi_bus_pkg::mem_rsp_t mem_rsp_i
);

  logic                           gnt, accept, amo_wb, buf_ready;
  logic                           sc_fail, res_exokay, is_sc;
  logic                           rvalid, err, exokay;
  logic [obi_bus_pkg::data_w-1:0] alu_result, operand, rdata;
  logic [obi_bus_pkg::id_w-1:0]   rid;
  atop_pkg::atop_e                op;

  assign is_sc     = (atop_pkg::atop_e'(obi_req_i.atop) == atop_pkg::SC);
  assign obi_rsp_o = '{gnt: gnt, rvalid: rvalid, rdata: rdata, rid: rid,
                       err: err, exokay: exokay};

  atop_sequencer i_atop_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .obi_req_i    (obi_req_i),
    .mem_rsp_i    (mem_rsp_i),
    .buf_ready_i  (buf_ready),
    .sc_fail_i    (sc_fail),
    .alu_result_i (alu_result),
    .gnt_o        (gnt),
    .accept_o     (accept),
    .amo_wb_o     (amo_wb),
    .mem_req_o    (mem_req_o),
    .op_o         (op),
    .operand_o    (operand)
  );

  atop_reservation i_atop_reservation (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .obi_req_i (obi_req_i),
    .accept_i  (accept),
    .sc_fail_o (sc_fail),
    .exokay_o  (res_exokay)
  );

  amo_alu i_amo_alu (
    .op_i       (op),
    .mem_word_i (mem_rsp_i.rdata),
    .operand_i  (operand),
    .result_o   (alu_result)
  );

  rsp_buffer i_rsp_buffer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .accept_i  (accept),
    .aid_i     (obi_req_i.aid),
    .sc_i      (is_sc),
    .exokay_i  (res_exokay),
    .amo_wb_i  (amo_wb),
    .mem_rsp_i (mem_rsp_i),
    .rready_i  (obi_req_i.rready),
    .ready_o   (buf_ready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rid_o     (rid),
    .err_o     (err),
    .exokay_o  (exokay)
  );

endmodule

// File: verif/atop_resolver_checker.sv
// ----------------------------------------------------------------------
// Protocol assertions for the atomic resolver, bound into the response
// buffer and the sequencer; unused inputs of a binding are tied off
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module atop_resolver_checker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           push_i,
  input  logic [1:0]                     fifo_cnt_i,
  input  logic                           rvalid_i,
  input  logic                           rready_i,
  input  logic [obi_bus_pkg::data_w-1:0] rdata_i,
  input  logic [obi_bus_pkg::id_w-1:0]   rid_i,
  input  logic                           amo_acc_i,
  input  logic                           wb_gnt_i,
  input  logic                           gnt_i
);

  // Running count of failed assertions
  int unsigned fail_cnt = 0;
  // Set from an accepted AMO until its write-back is granted
  logic        amo_busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      amo_busy_q <= 1'b0;
    end else if (amo_acc_i) begin
      amo_busy_q <= 1'b1;
    end else if (wb_gnt_i) begin
      amo_busy_q <= 1'b0;
    end
  end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fifo_cnt_i == 2'd2) |-> !push_i)
    else begin
      $error("response FIFO pushed while holding two entries");
      fail_cnt++;
    end

  // A response waits for rready without changing
  rvalid_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rvalid_i && !rready_i) |=> (rvalid_i && $stable(rdata_i) && $stable(rid_i)))
    else begin
      $error("response changed or dropped before rready");
      fail_cnt++;
    end

  gnt_low_during_amo: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_busy_q |-> !gnt_i)
    else begin
      $error("requester grant while an AMO is in progress");
      fail_cnt++;
    end

endmodule

bind rsp_buffer atop_resolver_checker i_buffer_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .push_i     (push),
  .fifo_cnt_i (f_cnt_q),
  .rvalid_i   (rvalid_o),
  .rready_i   (rready_i),
  .rdata_i    (rdata_o),
  .rid_i      (rid_o),
  .amo_acc_i  (1'b0),
  .wb_gnt_i   (1'b0),
  .gnt_i      (1'b0)
);

bind atop_sequencer atop_resolver_checker i_seq_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .push_i     (1'b0),
  .fifo_cnt_i (2'd0),
  .rvalid_i   (1'b0),
  .rready_i   (1'b1),
  .rdata_i    ({obi_bus_pkg::data_w{1'b0}}),
  .rid_i      ({obi_bus_pkg::id_w{1'b0}}),
  .amo_acc_i  (load_amo),
  .wb_gnt_i   (amo_wb_o && mem_rsp_i.gnt),
  .gnt_i      (gnt_o)
);

// File: verif/tb_atop_resolver.sv
// ----------------------------------------------------------------------
// Testbench of the atomic resolver: a 64-word memory model with random
// grants, directed and random requests, a shadow reference model and an
// in-order response compare. Run with compile.f, top tb_atop_resolver
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_atop_resolver;

  localparam int unsigned dw         = obi_bus_pkg::data_w;
  localparam int unsigned rand_items = 60;
  localparam int unsigned test_items = 2 + 2 * 9 * 3 + 3 + 4 + rand_items;
  localparam int unsigned wd_cycles  = 16 + 200 * test_items;

  // One expected response, in issue order
  typedef struct packed {
    logic [dw-1:0]                data;
    logic [obi_bus_pkg::id_w-1:0] id;
    logic                         exokay;
  } exp_t;

  logic                    clk_i = 1'b0;
  logic                    rst_ni = 1'b0;
  logic                    rready = 1'b1;
  logic                    stress = 1'b0;
  obi_bus_pkg::sbr_req_t   drv_req = '0;
  obi_bus_pkg::sbr_req_t   obi_req;
  obi_bus_pkg::sbr_rsp_t   obi_rsp;
  obi_bus_pkg::mem_req_t   mem_req;
  obi_bus_pkg::mem_rsp_t   mem_rsp = '0;

  logic [dw-1:0]           mem [64];
  logic [dw-1:0]           shadow [64];
  logic                    pend_q = 1'b0;
  logic [dw-1:0]           pend_data = '0;
  logic [obi_bus_pkg::id_w-1:0] acc_aid = '0;
  atop_pkg::reservation_t  res = '0;
  exp_t                    exp_q [$];
  int unsigned             n_checks = 0;
  int unsigned             n_errors = 0;
  int unsigned             n_tests = 0;
  int unsigned             base_checks = 0;
  int unsigned             base_errors = 0;
  atop_pkg::atop_e         amo_ops [9] = '{atop_pkg::AMOSWAP, atop_pkg::AMOADD,
                                           atop_pkg::AMOXOR, atop_pkg::AMOAND,
                                           atop_pkg::AMOOR, atop_pkg::AMOMIN,
                                           atop_pkg::AMOMAX, atop_pkg::AMOMINU,
                                           atop_pkg::AMOMAXU};

  always #4 clk_i = ~clk_i;

  always_comb begin
    obi_req        = drv_req;
    obi_req.rready = rready;
  end

  atop_resolver i_atop_resolver (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  // ----------------------------------------------------------------------
  // Memory model, answers one cycle after each grant
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (mem_req.req && mem_rsp.gnt) begin
      // A write-back carries the id of the AMO accepted before it
      check_id("mem aid", mem_req.aid, obi_rsp.gnt ? obi_req.aid : acc_aid);
      pend_q    <= 1'b1;
      pend_data <= mem_req.we ? '0 : mem[mem_req.addr[7:2]];
      for (int b = 0; b < 4; b++) begin
        if (mem_req.we && mem_req.be[b]) begin
          mem[mem_req.addr[7:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end
    end else begin
      pend_q <= 1'b0;
    end
  end

  always @(negedge clk_i) begin
    mem_rsp.rvalid = pend_q;
    mem_rsp.rdata  = pend_q ? pend_data : '0;
    mem_rsp.err    = 1'b0;
    if (stress) begin
      mem_rsp.gnt = ($urandom % 4) != 0;
      rready      = ($urandom % 3) != 0;
    end else begin
      mem_rsp.gnt = 1'b1;
      rready      = 1'b1;
    end
  end

  function automatic logic [dw-1:0] fill_word(input int unsigned idx);
    return 32'h3c00_0000 | (idx * 32'h0101_0007);
  endfunction

  // Memory word after an AMO, from the RISC-V definitions
  function automatic logic [dw-1:0] ref_amo(input atop_pkg::atop_e op,
                                            input logic [dw-1:0] old_word,
                                            input logic [dw-1:0] operand);
    case (op)
      atop_pkg::AMOSWAP: return operand;
      atop_pkg::AMOADD:  return old_word + operand;
      atop_pkg::AMOXOR:  return old_word ^ operand;
      atop_pkg::AMOAND:  return old_word & operand;
      atop_pkg::AMOOR:   return old_word | operand;
      atop_pkg::AMOMIN:  return ($signed(old_word) < $signed(operand)) ? old_word : operand;
      atop_pkg::AMOMAX:  return ($signed(old_word) > $signed(operand)) ? old_word : operand;
      atop_pkg::AMOMINU: return (old_word < operand) ? old_word : operand;
      atop_pkg::AMOMAXU: return (old_word > operand) ? old_word : operand;
      default:           return old_word;
    endcase
  endfunction

  // Applies an accepted request to the shadow state and queues its response
  task automatic predict(input atop_pkg::atop_e op, input logic [dw-1:0] addr,
                         input logic we, input logic [dw-1:0] wdata,
                         input logic [obi_bus_pkg::id_w-1:0] aid);
    exp_t       e;
    logic       ok;
    logic [5:0] idx;
    idx      = addr[7:2];
    e.id     = aid;
    e.exokay = 1'b0;
    e.data   = shadow[idx];
    if (op == atop_pkg::LR) begin
      e.exokay = 1'b1;
      if (!res.valid || res.owner == aid) begin
        res.valid = 1'b1;
        res.addr  = addr;
        res.owner = aid;
      end
    end else if (op == atop_pkg::SC) begin
      ok = res.valid && res.owner == aid && res.addr == addr;
      if (res.valid && res.owner == aid) begin
        res.valid = 1'b0;
      end
      e.data   = ok ? 32'd0 : 32'd1;
      e.exokay = ok;
      if (ok) begin
        shadow[idx] = wdata;
      end
    end else if (op != atop_pkg::NONE || we) begin
      // Stores from other requesters break the reservation
      if (res.addr == addr && res.owner != aid) begin
        res.valid = 1'b0;
      end
      if (op == atop_pkg::NONE) begin
        e.data      = '0;
        shadow[idx] = wdata;
      end else begin
        shadow[idx] = ref_amo(op, shadow[idx], wdata);
      end
    end
    exp_q.push_back(e);
  endtask

  // Called just after a falling edge, returns after the next one
  task automatic issue(input atop_pkg::atop_e op, input logic [dw-1:0] addr,
                       input logic we, input logic [dw-1:0] wdata,
                       input logic [obi_bus_pkg::id_w-1:0] aid);
    drv_req.req   = 1'b1;
    drv_req.addr  = addr;
    drv_req.we    = we;
    drv_req.be    = 4'hf;
    drv_req.wdata = wdata;
    drv_req.aid   = aid;
    drv_req.atop  = op;
    forever begin
      @(posedge clk_i);
      if (obi_rsp.gnt) break;
    end
    acc_aid = aid;
    predict(op, addr, we, wdata, aid);
    @(negedge clk_i);
    drv_req.req = 1'b0;
  endtask

  task automatic check_data(input string name, input logic [dw-1:0] got,
                            input logic [dw-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [obi_bus_pkg::id_w-1:0] got,
                          input logic [obi_bus_pkg::id_w-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Compares each response at its handshake
  always @(posedge clk_i) begin
    exp_t e;
    if (rst_ni && obi_rsp.rvalid && obi_req.rready) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("A response arrived with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        check_data("rdata", obi_rsp.rdata, e.data);
        check_id("rid", obi_rsp.rid, e.id);
        check_flag("exokay", obi_rsp.exokay, e.exokay);
        check_flag("err", obi_rsp.err, 1'b0);
      end
    end
  end

  task automatic end_test(input string name);
    while (exp_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
    n_tests++;
    $display("%-28s %0d checks, %0d errors", name, n_checks - base_checks,
             n_errors - base_errors);
    base_checks = n_checks;
    base_errors = n_errors;
  endtask

  initial begin
    repeat (wd_cycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles with responses still missing", wd_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [dw-1:0]   edge_old [2];
    logic [dw-1:0]   edge_opnd [2];
    int unsigned     pick;
    atop_pkg::atop_e op;
    void'($urandom(32'h5c7f));
    edge_old  = '{32'h8000_0000, 32'hffff_ffff};
    edge_opnd = '{32'h7fff_ffff, 32'h0000_0001};
    for (int i = 0; i < 64; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    issue(atop_pkg::NONE, 32'h10, 1'b1, 32'hcafe_0123, 4'h1);
    issue(atop_pkg::NONE, 32'h10, 1'b0, 32'h0, 4'h2);
    end_test("plain write and read");

    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 9; k++) begin
        issue(atop_pkg::NONE, 32'h20, 1'b1, edge_old[p], 4'h3);
        issue(amo_ops[k], 32'h20, 1'b1, edge_opnd[p], 4'h3);
        issue(atop_pkg::NONE, 32'h20, 1'b0, 32'h0, 4'h3);
      end
    end
    end_test("AMO results");

    issue(atop_pkg::LR, 32'h30, 1'b0, 32'h0, 4'h5);
    issue(atop_pkg::SC, 32'h30, 1'b1, 32'h1234_5678, 4'h5);
    issue(atop_pkg::NONE, 32'h30, 1'b0, 32'h0, 4'h5);
    end_test("LR/SC success");

    issue(atop_pkg::LR, 32'h34, 1'b0, 32'h0, 4'h6);
    issue(atop_pkg::NONE, 32'h34, 1'b1, 32'hdead_beef, 4'h7);
    issue(atop_pkg::SC, 32'h34, 1'b1, 32'h0bad_f00d, 4'h6);
    issue(atop_pkg::NONE, 32'h34, 1'b0, 32'h0, 4'h6);
    end_test("LR/SC broken by store");

    // Random mix with back-pressure on both sides
    stress = 1'b1;
    repeat (rand_items) begin
      pick = $urandom % 13;
      if (pick < 9) op = amo_ops[pick];
      else if (pick == 9) op = atop_pkg::LR;
      else if (pick == 10) op = atop_pkg::SC;
      else op = atop_pkg::NONE;
      issue(op, 32'h40 + 4 * ($urandom % 4), pick != 11, $urandom, 4'($urandom % 4));
    end
    end_test("random with back-pressure");
    stress = 1'b0;

    n_errors += i_atop_resolver.i_rsp_buffer.i_buffer_checker.fail_cnt;
    n_errors += i_atop_resolver.i_atop_sequencer.i_seq_checker.fail_cnt;
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/obi_bus_pkg.sv
src/atop_pkg.sv
src/atop_reservation.sv
src/atop_sequencer.sv
src/amo_alu.sv
src/rsp_buffer.sv
src/atop_resolver.sv
verif/atop_resolver_checker.sv
verif/tb_atop_resolver.sv
